// ==== all.f ====
verilog/rv32i_pkg.sv
verilog/rename_pkg.sv
verilog/sync_fifo.sv
verilog/rename_dispatch.sv
verilog/rat.sv
verilog/rob.sv
verilog/rrat.sv
verilog/rename_core.sv
testbench/rename_assertions.sv
testbench/rename_checker.sv
testbench/tb_rename_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the rename core testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f all.f --top-module tb_rename_core -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ALL TESTS PASSED" "$LOG"; then
    exit 0
fi
exit 1

// ==== testbench/rename_assertions.sv ====
module rename_assertions (
    input logic clk,
    input logic rst,
    input logic inst_valid_i,
    input logic iq_full_o,
    input logic rob_full,
    input logic dispatch_valid_o,
    input logic commit_valid_o
);

    timeunit 1ns;
    timeprecision 100ps;

    import rename_pkg::*;

    int inflight;   // ROB occupancy from the strobes

    always_ff @(posedge clk) begin
        if (rst) begin
            inflight <= 0;
        end else begin
            inflight <= inflight + int'(dispatch_valid_o) - int'(commit_valid_o);
        end
    end

    // A push into a full queue would be dropped silently
    no_push_when_full: assert property (
        @(posedge clk) disable iff (rst) inst_valid_i |-> !iq_full_o
    ) else $error("instruction pushed while the queue was full");

    no_dispatch_rob_full: assert property (
        @(posedge clk) disable iff (rst)
        (inflight == ROB_DEPTH) |-> (rob_full && !dispatch_valid_o)
    ) else $error("ROB full flag low or dispatch with all ROB entries in flight");

    quiet_in_reset: assert property (
        @(posedge clk) (rst && $past(rst)) |-> (!dispatch_valid_o && !commit_valid_o)
    ) else $error("dispatch or commit strobe high during reset");

endmodule : rename_assertions

// ==== testbench/rename_checker.sv ====
module rename_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  inst_valid_i,
    input rv32i_pkg::inst_t      inst_i,
    input logic                  iq_full_i,
    input rename_pkg::cdb_t      cdb_i,
    input logic                  dispatch_valid_i,
    input rename_pkg::dispatch_t dispatch_i,
    input logic                  commit_valid_i,
    input rename_pkg::commit_t   commit_i
);

    timeunit 1ns;
    timeprecision 100ps;

    import rv32i_pkg::*;
    import rename_pkg::*;

    phys_reg_t map_m [32];
    logic      ready_m [32];
    phys_reg_t rrat_m [32];
    logic      done_m [32];
    inst_t     inst_q [$];
    phys_reg_t free_q [$];
    dispatch_t commit_q [$];
    rob_idx_t  tail_m;
    dispatch_t exp_d;
    phys_reg_t old_m;
    logic      exp_dv;
    logic      exp_cv;
    int        dispatch_errors = 0;
    int        commit_errors = 0;
    int        max_inflight = 0;

    // Branch and store have no rd, x0 is never written
    function automatic logic writes_reg(input inst_t inst);
        return (inst[6:0] != 7'b1100011) && (inst[6:0] != 7'b0100011) && (inst[11:7] != 5'd0);
    endfunction

    function automatic dispatch_t expected_dispatch(input inst_t inst);
        dispatch_t d;
        d.rd        = inst[11:7];
        d.rd_we     = writes_reg(inst);
        d.pd        = d.rd_we ? free_q[0] : phys_reg_t'(0);
        d.ps1       = map_m[inst[19:15]];
        d.ps2       = map_m[inst[24:20]];
        d.ps1_ready = ready_m[inst[19:15]];
        d.ps2_ready = ready_m[inst[24:20]];
        d.rob_idx   = tail_m;
        return d;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp, input bit on_commit);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
            if (on_commit) commit_errors++;
            else dispatch_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                map_m[i]   = phys_reg_t'(i);
                ready_m[i] = 1'b1;
                rrat_m[i]  = phys_reg_t'(i);
                done_m[i]  = 1'b0;
            end
            inst_q.delete();
            commit_q.delete();
            free_q.delete();
            for (int i = 32; i < 64; i++) free_q.push_back(phys_reg_t'(i));
            tail_m = '0;
        end else begin
            check_val("iq_full_o", 32'(iq_full_i), 32'(inst_q.size() == IQ_DEPTH), 0);
            exp_dv = (inst_q.size() > 0) && (commit_q.size() < ROB_DEPTH);
            if (exp_dv && writes_reg(inst_q[0]) && free_q.size() == 0) exp_dv = 1'b0;
            check_val("dispatch_valid_o", 32'(dispatch_valid_i), 32'(exp_dv), 0);
            if (exp_dv) begin
                exp_d = expected_dispatch(inst_q[0]);
            end
            if (dispatch_valid_i && exp_dv) begin
                check_val("dispatch_o.rd", 32'(dispatch_i.rd), 32'(exp_d.rd), 0);
                check_val("dispatch_o.rd_we", 32'(dispatch_i.rd_we), 32'(exp_d.rd_we), 0);
                check_val("dispatch_o.pd", 32'(dispatch_i.pd), 32'(exp_d.pd), 0);
                check_val("dispatch_o.ps1", 32'(dispatch_i.ps1), 32'(exp_d.ps1), 0);
                check_val("dispatch_o.ps2", 32'(dispatch_i.ps2), 32'(exp_d.ps2), 0);
                check_val("dispatch_o.ps1_ready", 32'(dispatch_i.ps1_ready),
                          32'(exp_d.ps1_ready), 0);
                check_val("dispatch_o.ps2_ready", 32'(dispatch_i.ps2_ready),
                          32'(exp_d.ps2_ready), 0);
                check_val("dispatch_o.rob_idx", 32'(dispatch_i.rob_idx), 32'(exp_d.rob_idx), 0);
            end
            // Head must be done before this edge, a same-cycle CDB is too late
            exp_cv = (commit_q.size() > 0) && done_m[commit_q[0].rob_idx];
            check_val("commit_valid_o", 32'(commit_valid_i), 32'(exp_cv), 1);
            if (commit_valid_i && exp_cv) begin
                old_m = rrat_m[commit_q[0].rd];
                check_val("commit_o.rd", 32'(commit_i.rd), 32'(commit_q[0].rd), 1);
                check_val("commit_o.rd_we", 32'(commit_i.rd_we), 32'(commit_q[0].rd_we), 1);
                check_val("commit_o.pd", 32'(commit_i.pd), 32'(commit_q[0].pd), 1);
                check_val("commit_o.old_pd", 32'(commit_i.old_pd), 32'(old_m), 1);
            end
            // CDB first, so a same-cycle dispatch to that register wins
            if (cdb_i.valid) begin
                done_m[cdb_i.rob_idx] = 1'b1;
                if (cdb_i.rd_we) begin
                    for (int i = 1; i < 32; i++) begin
                        if (map_m[i] == cdb_i.pd) ready_m[i] = 1'b1;
                    end
                end
            end
            if (exp_dv) begin
                void'(inst_q.pop_front());
                if (exp_d.rd_we) begin
                    void'(free_q.pop_front());
                    map_m[exp_d.rd]   = exp_d.pd;
                    ready_m[exp_d.rd] = 1'b0;
                end
                done_m[tail_m] = 1'b0;
                commit_q.push_back(exp_d);
                tail_m = tail_m + 1'b1;
            end
            if (exp_cv) begin
                exp_d = commit_q.pop_front();
                done_m[exp_d.rob_idx] = 1'b0;
                if (exp_d.rd_we) begin
                    free_q.push_back(rrat_m[exp_d.rd]);
                    rrat_m[exp_d.rd] = exp_d.pd;
                end
            end
            if (inst_valid_i && !iq_full_i) inst_q.push_back(inst_i);
            if (commit_q.size() > max_inflight) max_inflight = commit_q.size();
        end
    end

endmodule : rename_checker

// ==== testbench/tb_rename_core.sv ====
module tb_rename_core;

    timeunit 1ns;
    timeprecision 100ps;

    import rv32i_pkg::*;
    import rename_pkg::*;

    localparam int NUM_INSTS   = 200;
    localparam int CYCLE_LIMIT = NUM_INSTS * 40 + 1000;

    logic      clk;
    logic      rst;
    logic      inst_valid_i;
    inst_t     inst_i;
    cdb_t      cdb_i;
    logic      iq_full_o;
    logic      dispatch_valid_o;
    dispatch_t dispatch_o;
    logic      commit_valid_o;
    commit_t   commit_o;

    logic [15:0] lfsr_q;
    dispatch_t   pending_q [$];
    int          pushed = 0;
    int          committed = 0;
    int          cycles = 0;
    int          gap = 0;
    int          withhold_cycles = 0;
    int          other_errors = 0;
    int          total_errors;
    logic        withhold = 1'b0;
    logic        saw_full = 1'b0;

    always #10 clk = ~clk;

    rename_core dut0 (.*);

    rename_checker checker0 (
        .clk(clk), .rst(rst),
        .inst_valid_i(inst_valid_i), .inst_i(inst_i), .iq_full_i(iq_full_o),
        .cdb_i(cdb_i),
        .dispatch_valid_i(dispatch_valid_o), .dispatch_i(dispatch_o),
        .commit_valid_i(commit_valid_o), .commit_i(commit_o)
    );

    bind rename_core rename_assertions assertions0 (
        .clk(clk), .rst(rst), .inst_valid_i(inst_valid_i), .iq_full_o(iq_full_o),
        .rob_full(rob_full), .dispatch_valid_o(dispatch_valid_o),
        .commit_valid_o(commit_valid_o)
    );

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[6:0], lfsr_q[0]};
        end
    endtask

    function automatic logic [6:0] pick_opcode(input logic [7:0] sel);
        case (sel % 9)
            0: return OPC_LUI;
            1: return OPC_AUIPC;
            2: return OPC_JAL;
            3: return OPC_JALR;
            4: return OPC_BRANCH;
            5: return OPC_LOAD;
            6: return OPC_STORE;
            7: return OPC_OP_IMM;
            default: return OPC_OP;
        endcase
    endfunction

    // Registers x0..x7 only, for many dependencies
    task automatic make_inst(output inst_t inst);
        logic [7:0] sel;
        logic [7:0] rd;
        logic [7:0] rs1;
        logic [7:0] rs2;
        take_bits(4, sel);
        take_bits(3, rd);
        take_bits(3, rs1);
        take_bits(3, rs2);
        inst = {7'b0, rs2[4:0], rs1[4:0], 3'b0, rd[4:0], pick_opcode(sel)};
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (dispatch_valid_o) pending_q.push_back(dispatch_o);
            if (commit_valid_o) committed++;
            if (iq_full_o) saw_full = 1'b1;
        end
    end

    initial begin
        logic [7:0] r;
        int         k;
        clk          = 1'b0;
        rst          = 1'b1;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        cdb_i        = '0;
        lfsr_q       = 16'd63551;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        while (committed < NUM_INSTS && cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            #2;
            cycles++;
            inst_valid_i = 1'b0;
            if (pushed < NUM_INSTS && !iq_full_o) begin
                if (gap > 0) begin
                    gap--;
                end else begin
                    make_inst(inst_i);
                    inst_valid_i = 1'b1;
                    pushed++;
                    take_bits(2, r);
                    gap = r;
                end
            end
            // Hold completions so the ROB and the queue fill up
            withhold = (pushed >= 60) && (withhold_cycles < 150);
            if (withhold) withhold_cycles++;
            cdb_i = '0;
            if (!withhold && pending_q.size() > 0) begin
                take_bits(1, r);
                if (r[0]) begin
                    take_bits(5, r);
                    k = r % pending_q.size();
                    cdb_i.valid   = 1'b1;
                    cdb_i.rob_idx = pending_q[k].rob_idx;
                    cdb_i.pd      = pending_q[k].pd;
                    cdb_i.rd_we   = pending_q[k].rd_we;
                    pending_q.delete(k);
                end
            end
        end
        inst_valid_i = 1'b0;
        cdb_i        = '0;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, only %0d of %0d instructions committed",
                     cycles, committed, NUM_INSTS);
            other_errors++;
        end
        if (!saw_full) begin
            $display("Instruction queue never reported full");
            other_errors++;
        end
        if (checker0.max_inflight != ROB_DEPTH) begin
            $display("ROB never held %0d entries, peak was %0d", ROB_DEPTH, checker0.max_inflight);
            other_errors++;
        end
        total_errors = checker0.dispatch_errors + checker0.commit_errors + other_errors;
        $display("Errors: %0d dispatch, %0d commit, %0d other", checker0.dispatch_errors,
                 checker0.commit_errors, other_errors);
        if (total_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : tb_rename_core

// ==== verilog/rat.sv ====
module rat (
    input  logic                  clk,
    input  logic                  rst,
    input  rv32i_pkg::arch_reg_t  rs1_i,
    input  rv32i_pkg::arch_reg_t  rs2_i,
    input  logic                  dispatch_valid_i,
    input  rename_pkg::dispatch_t dispatch_i,
    input  rename_pkg::cdb_t      cdb_i,
    output rename_pkg::phys_reg_t ps1_o,
    output rename_pkg::phys_reg_t ps2_o,
    output logic                  ps1_ready_o,
    output logic                  ps2_ready_o
);

    import rv32i_pkg::*;
    import rename_pkg::*;

    phys_reg_t                map_q [NUM_ARCH_REGS];
    logic [NUM_ARCH_REGS-1:0] ready_q;

    // Reads see the state from before the edge
    assign ps1_o       = map_q[rs1_i];
    assign ps2_o       = map_q[rs2_i];
    assign ps1_ready_o = ready_q[rs1_i];
    assign ps2_ready_o = ready_q[rs2_i];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);     // Identity map
            end
            ready_q <= '1;
        end else begin
            if (cdb_i.valid && cdb_i.rd_we) begin
                for (int i = 1; i < NUM_ARCH_REGS; i++) begin
                    if (map_q[i] == cdb_i.pd) begin
                        ready_q[i] <= 1'b1;
                    end
                end
            end
            // Later assignment, so dispatch beats a same-cycle CDB
            if (dispatch_valid_i && dispatch_i.rd_we && dispatch_i.rd != '0) begin
                map_q[dispatch_i.rd]   <= dispatch_i.pd;
                ready_q[dispatch_i.rd] <= 1'b0;
            end
        end
    end

endmodule : rat

// ==== verilog/rename_core.sv ====
module rename_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  inst_valid_i,
    input  rv32i_pkg::inst_t      inst_i,
    input  rename_pkg::cdb_t      cdb_i,
    output logic                  iq_full_o,
    output logic                  dispatch_valid_o,
    output rename_pkg::dispatch_t dispatch_o,
    output logic                  commit_valid_o,
    output rename_pkg::commit_t   commit_o
);

    import rv32i_pkg::*;
    import rename_pkg::*;

    inst_t     iq_head;
    logic      iq_empty;
    logic      iq_dequeue;
    phys_reg_t free_pd;
    logic      free_empty;
    logic      free_dequeue;
    logic      free_enqueue;
    phys_reg_t freed_pd;
    arch_reg_t rs1;
    arch_reg_t rs2;
    phys_reg_t ps1;
    phys_reg_t ps2;
    logic      ps1_ready;
    logic      ps2_ready;
    rob_idx_t  rob_tail;
    logic      rob_full;
    logic      head_valid;
    dispatch_t rob_head;

    sync_fifo #(
        .DATA_WIDTH ($bits(inst_t)),
        .DEPTH      (IQ_DEPTH),
        .PRELOAD    (1'b0),
        .PRELOAD_BASE (0)
    ) iq0 (
        .clk(clk),
        .rst(rst),
        .wdata_i(inst_i),
        .enqueue_i(inst_valid_i),
        .dequeue_i(iq_dequeue),
        .rdata_o(iq_head),
        .full_o(iq_full_o),
        .empty_o(iq_empty)
    );

    // Starts holding the registers above the identity map
    sync_fifo #(
        .DATA_WIDTH ($bits(phys_reg_t)),
        .DEPTH      (FREE_LIST_DEPTH),
        .PRELOAD    (1'b1),
        .PRELOAD_BASE (NUM_PHYS_REGS - FREE_LIST_DEPTH)
    ) free_list0 (
        .clk(clk),
        .rst(rst),
        .wdata_i(freed_pd),
        .enqueue_i(free_enqueue),
        .dequeue_i(free_dequeue),
        .rdata_o(free_pd),
        .full_o(),              // Cannot fill while any writer is in flight
        .empty_o(free_empty)
    );

    rename_dispatch rename_dispatch0 (
        .inst_i(iq_head),
        .iq_empty_i(iq_empty),
        .rob_full_i(rob_full),
        .free_empty_i(free_empty),
        .free_pd_i(free_pd),
        .rob_tail_i(rob_tail),
        .ps1_i(ps1),
        .ps2_i(ps2),
        .ps1_ready_i(ps1_ready),
        .ps2_ready_i(ps2_ready),
        .rs1_o(rs1),
        .rs2_o(rs2),
        .iq_dequeue_o(iq_dequeue),
        .free_dequeue_o(free_dequeue),
        .dispatch_valid_o(dispatch_valid_o),
        .dispatch_o(dispatch_o)
    );

    rat rat0 (
        .clk(clk),
        .rst(rst),
        .rs1_i(rs1),
        .rs2_i(rs2),
        .dispatch_valid_i(dispatch_valid_o),
        .dispatch_i(dispatch_o),
        .cdb_i(cdb_i),
        .ps1_o(ps1),
        .ps2_o(ps2),
        .ps1_ready_o(ps1_ready),
        .ps2_ready_o(ps2_ready)
    );

    rob rob0 (
        .clk(clk),
        .rst(rst),
        .dispatch_valid_i(dispatch_valid_o),
        .dispatch_i(dispatch_o),
        .cdb_i(cdb_i),
        .tail_o(rob_tail),
        .full_o(rob_full),
        .head_valid_o(head_valid),
        .head_o(rob_head)
    );

    rrat rrat0 (
        .clk(clk),
        .rst(rst),
        .commit_valid_i(head_valid),
        .head_i(rob_head),
        .commit_valid_o(commit_valid_o),
        .commit_o(commit_o),
        .free_enqueue_o(free_enqueue),
        .free_pd_o(freed_pd)
    );

endmodule : rename_core

// ==== verilog/rename_dispatch.sv ====
module rename_dispatch (
    input  rv32i_pkg::inst_t      inst_i,
    input  logic                  iq_empty_i,
    input  logic                  rob_full_i,
    input  logic                  free_empty_i,
    input  rename_pkg::phys_reg_t free_pd_i,
    input  rename_pkg::rob_idx_t  rob_tail_i,
    input  rename_pkg::phys_reg_t ps1_i,
    input  rename_pkg::phys_reg_t ps2_i,
    input  logic                  ps1_ready_i,
    input  logic                  ps2_ready_i,
    output rv32i_pkg::arch_reg_t  rs1_o,
    output rv32i_pkg::arch_reg_t  rs2_o,
    output logic                  iq_dequeue_o,
    output logic                  free_dequeue_o,
    output logic                  dispatch_valid_o,
    output rename_pkg::dispatch_t dispatch_o
);

    import rv32i_pkg::*;
    import rename_pkg::*;

    opcode_e   opcode;
    arch_reg_t rd;
    logic      writes_rd;

    // Fixed RV32I field positions
    assign opcode = opcode_e'(inst_i[6:0]);
    assign rd     = inst_i[11:7];
    assign rs1_o  = inst_i[19:15];
    assign rs2_o  = inst_i[24:20];

    // Branches and stores have no rd, x0 is never renamed
    assign writes_rd = (opcode != OPC_BRANCH) && (opcode != OPC_STORE) && (rd != '0);

    // Free list only matters for a register-writing instruction
    always_comb begin
        dispatch_valid_o = !iq_empty_i && !rob_full_i;
        if (writes_rd && free_empty_i) begin
            dispatch_valid_o = 1'b0;
        end
    end

    assign iq_dequeue_o   = dispatch_valid_o;
    assign free_dequeue_o = dispatch_valid_o && writes_rd;

    always_comb begin
        dispatch_o.rd        = rd;
        dispatch_o.rd_we     = writes_rd;
        dispatch_o.pd        = writes_rd ? free_pd_i : '0;
        dispatch_o.ps1       = ps1_i;
        dispatch_o.ps2       = ps2_i;
        dispatch_o.ps1_ready = ps1_ready_i;
        dispatch_o.ps2_ready = ps2_ready_i;
        dispatch_o.rob_idx   = rob_tail_i;
    end

endmodule : rename_dispatch

// ==== verilog/rename_pkg.sv ====
package rename_pkg;

    localparam int NUM_PHYS_REGS   = 64;
    localparam int ROB_DEPTH       = 32;
    localparam int IQ_DEPTH        = 8;
    localparam int FREE_LIST_DEPTH = 32;

    typedef logic [$clog2(NUM_PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(ROB_DEPTH)-1:0]     rob_idx_t;

    typedef struct packed {
        rv32i_pkg::arch_reg_t rd;
        logic                 rd_we;
        phys_reg_t            pd;
        phys_reg_t            ps1;
        phys_reg_t            ps2;
        logic                 ps1_ready;
        logic                 ps2_ready;
        rob_idx_t             rob_idx;
    } dispatch_t;

    typedef struct packed {
        logic      valid;
        rob_idx_t  rob_idx;
        phys_reg_t pd;
        logic      rd_we;
    } cdb_t;

    typedef struct packed {
        rv32i_pkg::arch_reg_t rd;
        logic                 rd_we;
        phys_reg_t            pd;
        phys_reg_t            old_pd;
    } commit_t;

endpackage : rename_pkg

// ==== verilog/rob.sv ====
module rob (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatch_valid_i,
    input  rename_pkg::dispatch_t dispatch_i,
    input  rename_pkg::cdb_t      cdb_i,
    output rename_pkg::rob_idx_t  tail_o,
    output logic                  full_o,
    output logic                  head_valid_o,
    output rename_pkg::dispatch_t head_o
);

    import rename_pkg::*;

    dispatch_t            entry_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] valid_q;
    logic [ROB_DEPTH-1:0] done_q;
    rob_idx_t             head_q;
    rob_idx_t             tail_q;
    logic                 alloc;

    assign tail_o = tail_q;
    assign full_o = valid_q[tail_q];    // Tail caught up with head

    // Head commits as soon as it is done
    assign head_valid_o = valid_q[head_q] && done_q[head_q];
    assign head_o       = entry_q[head_q];

    assign alloc = dispatch_valid_i && !full_o;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
        end else begin
            if (cdb_i.valid && valid_q[cdb_i.rob_idx]) begin
                done_q[cdb_i.rob_idx] <= 1'b1;
            end
            if (head_valid_o) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            if (alloc) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            entry_q[tail_q] <= dispatch_i;
        end
    end

endmodule : rob

// ==== verilog/rrat.sv ====
module rrat (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  commit_valid_i,
    input  rename_pkg::dispatch_t head_i,
    output logic                  commit_valid_o,
    output rename_pkg::commit_t   commit_o,
    output logic                  free_enqueue_o,
    output rename_pkg::phys_reg_t free_pd_o
);

    import rv32i_pkg::*;
    import rename_pkg::*;

    phys_reg_t map_q [NUM_ARCH_REGS];
    phys_reg_t old_pd;

    assign old_pd = map_q[head_i.rd];   // Committed mapping before this commit

    assign commit_valid_o  = commit_valid_i;
    assign commit_o.rd     = head_i.rd;
    assign commit_o.rd_we  = head_i.rd_we;
    assign commit_o.pd     = head_i.pd;
    assign commit_o.old_pd = old_pd;

    // Displaced register goes back to the free list
    assign free_enqueue_o = commit_valid_i && head_i.rd_we;
    assign free_pd_o      = old_pd;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                map_q[i] <= phys_reg_t'(i);
            end
        end else if (free_enqueue_o) begin
            map_q[head_i.rd] <= head_i.pd;
        end
    end

endmodule : rrat

// ==== verilog/rv32i_pkg.sv ====
package rv32i_pkg;

    localparam int NUM_ARCH_REGS = 32;

    typedef logic [31:0] inst_t;
    typedef logic [4:0]  arch_reg_t;

    // RV32I major opcodes, bits [6:0]
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

endpackage : rv32i_pkg

// ==== verilog/sync_fifo.sv ====
module sync_fifo #(
    parameter int DATA_WIDTH   = 32,
    parameter int DEPTH        = 8,
    parameter bit PRELOAD      = 1'b0,
    parameter int PRELOAD_BASE = 0
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [DATA_WIDTH-1:0] wdata_i,
    input  logic                  enqueue_i,
    input  logic                  dequeue_i,
    output logic [DATA_WIDTH-1:0] rdata_o,
    output logic                  full_o,
    output logic                  empty_o
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [PTR_W-1:0]      rd_ptr_q;
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [CNT_W-1:0]      count_q;
    logic                  do_enq;
    logic                  do_deq;

    assign full_o  = (count_q == CNT_W'(DEPTH));
    assign empty_o = (count_q == '0);
    assign rdata_o = mem[rd_ptr_q];     // Head visible combinationally

    assign do_enq = enqueue_i && !full_o;   // Push while full is dropped
    assign do_deq = dequeue_i && !empty_o;

    // Pointers wrap naturally, DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= PRELOAD ? CNT_W'(DEPTH) : '0;
        end else begin
            if (do_enq) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_deq) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            count_q <= count_q + CNT_W'(do_enq) - CNT_W'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (rst && PRELOAD) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= DATA_WIDTH'(PRELOAD_BASE + i);    // Consecutive values
            end
        end else if (do_enq) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

endmodule : sync_fifo
